// File: hdl/sound.sv
// sound card top level
// qualifies the host strobes with sb_cs, muxes readback and routes the irq
// to line 5, 7 or 10 as picked in mixer register 80
`timescale 1ns/1ps
`default_nettype none

module sound (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [3:0]  address,
	input  logic        read,
	input  logic        write,
	input  logic [7:0]  writedata,
	input  logic        sb_cs,
	input  logic [27:0] clock_rate,
	output logic        irq_5,
	output logic        irq_7,
	output logic        irq_10,
	output logic [7:0]  readdata,
	output logic [4:0]  vol_l,
	output logic [4:0]  vol_r,
	output logic [4:0]  vol_midi_l,
	output logic [4:0]  vol_midi_r,
	output logic [4:0]  vol_cd_l,
	output logic [4:0]  vol_cd_r,
	output logic [4:0]  vol_line_l,
	output logic [4:0]  vol_line_r,
	output logic [15:0] sample_l,
	output logic [15:0] sample_r
);

	logic        sb_read;
	logic        sb_write;
	logic        ce_1us;
	logic [7:0]  mixer_data;
	logic [7:0]  dsp_data;
	logic        irq8;
	logic        irq_sel_7;
	logic        irq_sel_10;
	logic [4:0]  vol_voice_l;
	logic [4:0]  vol_voice_r;
	logic [15:0] dac_sample;

	assign sb_read  = read && sb_cs;
	assign sb_write = write && sb_cs;

	always_ff @(posedge clk) begin
		if (sb_read)
			readdata <= (address == sound_pkg::port_mix_data) ? mixer_data : dsp_data;
	end

	assign irq_5  = irq8 && !irq_sel_7 && !irq_sel_10; // default line
	assign irq_7  = irq8 && irq_sel_7;
	assign irq_10 = irq8 && irq_sel_10;

	sound_rate_tick rate_tick (
		.clk        (clk),
		.rst_n      (rst_n),
		.clock_rate (clock_rate),
		.ce_1us     (ce_1us)
	);

	sound_mixer_regs mixer (
		.clk          (clk),
		.rst_n        (rst_n),
		.sb_write     (sb_write),
		.address      (address),
		.writedata    (writedata),
		.irq8         (irq8),
		.mixer_data   (mixer_data),
		.vol_voice_l  (vol_voice_l),
		.vol_voice_r  (vol_voice_r),
		.vol_master_l (vol_l),
		.vol_master_r (vol_r),
		.vol_midi_l   (vol_midi_l),
		.vol_midi_r   (vol_midi_r),
		.vol_cd_l     (vol_cd_l),
		.vol_cd_r     (vol_cd_r),
		.vol_line_l   (vol_line_l),
		.vol_line_r   (vol_line_r),
		.irq_sel_7    (irq_sel_7),
		.irq_sel_10   (irq_sel_10)
	);

	sound_dsp dsp (
		.clk        (clk),
		.rst_n      (rst_n),
		.ce_1us     (ce_1us),
		.sb_read    (sb_read),
		.sb_write   (sb_write),
		.address    (address),
		.writedata  (writedata),
		.dsp_data   (dsp_data),
		.irq8       (irq8),
		.dac_sample (dac_sample)
	);

	// mono dsp, one sample into both channels
	sound_volume vol_left (
		.clk        (clk),
		.rst_n      (rst_n),
		.sample_in  (dac_sample),
		.level      (vol_voice_l),
		.sample_out (sample_l)
	);

	sound_volume vol_right (
		.clk        (clk),
		.rst_n      (rst_n),
		.sample_in  (dac_sample),
		.level      (vol_voice_r),
		.sample_out (sample_r)
	);

endmodule

`default_nettype wire

// File: hdl/sound_dsp.sv
// reduced sound blaster dsp
// handles reset/ready, direct dac output, version query and irq raise
// dsp_data is the read value for the current address, sampled by the top
`timescale 1ns/1ps
`default_nettype none

module sound_dsp (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        ce_1us,
	input  logic        sb_read,
	input  logic        sb_write,
	input  logic [3:0]  address,
	input  logic [7:0]  writedata,
	output logic [7:0]  dsp_data,
	output logic        irq8,
	output logic [15:0] dac_sample
);

	logic        dsp_rst;  // held in reset by port 6
	logic        counting; // waiting for the ready byte
	logic [15:0] rst_cnt;
	logic [7:0]  q_head;
	logic [7:0]  q_tail;
	logic [1:0]  q_count;
	logic        dac_pending; // next command byte is a sample
	logic [7:0]  dac_byte;
	logic        rst_wr;
	logic        cmd_wr;
	logic        stat_rd;
	logic        data_rd;

	assign rst_wr  = sb_write && address == sound_pkg::port_dsp_reset;
	assign cmd_wr  = sb_write && address == sound_pkg::port_dsp_cmd && !dsp_rst && !counting;
	assign stat_rd = sb_read && address == sound_pkg::port_dsp_status;
	assign data_rd = sb_read && address == sound_pkg::port_dsp_read;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dsp_rst     <= 1'b0;
			counting    <= 1'b0;
			rst_cnt     <= 16'd0;
			q_count     <= 2'd0;
			dac_pending <= 1'b0;
			dac_byte    <= 8'h80; // midscale, silent
			irq8        <= 1'b0;
		end else begin
			if (rst_wr) begin
				if (writedata[0]) begin
					dsp_rst     <= 1'b1;
					counting    <= 1'b0;
					q_count     <= 2'd0;
					dac_pending <= 1'b0;
					irq8        <= 1'b0;
				end else if (dsp_rst) begin
					dsp_rst  <= 1'b0;
					counting <= 1'b1;
					rst_cnt  <= sound_pkg::dsp_reset_us;
				end
			end else if (counting && ce_1us) begin
				rst_cnt <= rst_cnt - 16'd1;
				if (rst_cnt == 16'd1) begin
					counting <= 1'b0;
					q_head   <= sound_pkg::dsp_ready_byte;
					q_count  <= 2'd1;
				end
			end

			if (cmd_wr) begin
				if (dac_pending) begin
					dac_byte    <= writedata;
					dac_pending <= 1'b0;
				end else begin
					case (writedata)
						sound_pkg::cmd_direct_dac: dac_pending <= 1'b1;
						sound_pkg::cmd_version: begin
							q_head  <= sound_pkg::dsp_version_major;
							q_tail  <= sound_pkg::dsp_version_minor;
							q_count <= 2'd2; // overwrites whatever was queued
						end
						sound_pkg::cmd_irq8: irq8 <= 1'b1;
						default: ;
					endcase
				end
			end

			if (stat_rd)
				irq8 <= 1'b0; // status read acknowledges
			if (data_rd && q_count != 2'd0) begin
				q_head  <= q_tail;
				q_count <= q_count - 2'd1;
			end
		end
	end

	always_comb begin
		case (address)
			sound_pkg::port_dsp_status: dsp_data = {q_count != 2'd0, 7'd0};
			sound_pkg::port_dsp_read:   dsp_data = q_head;
			default:                    dsp_data = 8'h00;
		endcase
	end

	// unsigned byte to signed, upper half of the word
	assign dac_sample = {~dac_byte[7], dac_byte[6:0], 8'h00};

endmodule

`default_nettype wire

// File: hdl/sound_mixer_regs.sv
// mixer register bank behind the index and data ports
// holds all volume levels, irq select and pro/sb16 mode
// mixer_data follows the index one cycle later
`timescale 1ns/1ps
`default_nettype none

module sound_mixer_regs (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       sb_write,
	input  logic [3:0] address,
	input  logic [7:0] writedata,
	input  logic       irq8,
	output logic [7:0] mixer_data,
	output logic [4:0] vol_voice_l,
	output logic [4:0] vol_voice_r,
	output logic [4:0] vol_master_l,
	output logic [4:0] vol_master_r,
	output logic [4:0] vol_midi_l,
	output logic [4:0] vol_midi_r,
	output logic [4:0] vol_cd_l,
	output logic [4:0] vol_cd_r,
	output logic [4:0] vol_line_l,
	output logic [4:0] vol_line_r,
	output logic       irq_sel_7,
	output logic       irq_sel_10
);

	logic [7:0]             index;
	logic                   pro_mode; // sb16 level registers locked out
	logic                   index_wr;
	logic                   data_wr;
	logic                   irq_sel_5;
	sound_pkg::mixer_byte_u wr_byte;
	sound_pkg::mixer_byte_u rd_byte;

	// nibble to 5-bit level
	function automatic logic [4:0] expand(input logic [3:0] nib);
		return {nib, nib[3]};
	endfunction

	function automatic logic [7:0] pro_read(input logic [4:0] l, input logic [4:0] r,
		input logic masked);
		sound_pkg::mixer_byte_u b;
		b.pro.left  = l[4:1];
		b.pro.right = r[4:1];
		return masked ? (b & 8'hEE) : b;
	endfunction

	function automatic logic [7:0] sb16_read(input logic [4:0] level);
		sound_pkg::mixer_byte_u b;
		b.sb16.level  = level;
		b.sb16.unused = 3'b000;
		return b;
	endfunction

	assign index_wr  = sb_write && address == sound_pkg::port_mix_index;
	assign data_wr   = sb_write && address == sound_pkg::port_mix_data;
	assign wr_byte   = writedata;
	assign irq_sel_5 = !irq_sel_7 && !irq_sel_10;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			index      <= 8'h00;
			pro_mode   <= 1'b0;
			irq_sel_7  <= 1'b0;
			irq_sel_10 <= 1'b0;
		end else if (index_wr) begin
			index <= writedata;
		end else if (data_wr && index == sound_pkg::mix_irq_sel) begin
			if (writedata == sound_pkg::mode_pro_on)
				pro_mode <= 1'b1;
			else if (writedata == sound_pkg::mode_pro_off)
				pro_mode <= 1'b0;
			else begin
				irq_sel_7  <= writedata[3:2] == 2'b01;
				irq_sel_10 <= writedata[3:2] == 2'b10;
			end
		end
	end

	// index 00 write acts like a reset of the levels
	always_ff @(posedge clk) begin
		if (!rst_n || (data_wr && index == sound_pkg::mix_reset)) begin
			{vol_voice_l, vol_voice_r}   <= {2{sound_pkg::vol_reset}};
			{vol_master_l, vol_master_r} <= {2{sound_pkg::vol_reset}};
			{vol_midi_l, vol_midi_r}     <= {2{sound_pkg::vol_reset}};
			{vol_cd_l, vol_cd_r}         <= {2{sound_pkg::vol_reset}};
			{vol_line_l, vol_line_r}     <= {2{sound_pkg::vol_reset}};
		end else if (data_wr) begin
			case (index)
				sound_pkg::mix_voice: begin
					vol_voice_l <= expand(wr_byte.pro.left);
					vol_voice_r <= expand(wr_byte.pro.right);
				end
				sound_pkg::mix_master: begin
					vol_master_l <= expand(wr_byte.pro.left);
					vol_master_r <= expand(wr_byte.pro.right);
				end
				sound_pkg::mix_midi: begin
					vol_midi_l <= expand(wr_byte.pro.left);
					vol_midi_r <= expand(wr_byte.pro.right);
				end
				sound_pkg::mix_cd: begin
					vol_cd_l <= expand(wr_byte.pro.left);
					vol_cd_r <= expand(wr_byte.pro.right);
				end
				sound_pkg::mix_line: begin
					vol_line_l <= expand(wr_byte.pro.left);
					vol_line_r <= expand(wr_byte.pro.right);
				end
				sound_pkg::sb16_master_l: if (!pro_mode) vol_master_l <= wr_byte.sb16.level;
				sound_pkg::sb16_master_r: if (!pro_mode) vol_master_r <= wr_byte.sb16.level;
				sound_pkg::sb16_voice_l:  if (!pro_mode) vol_voice_l <= wr_byte.sb16.level;
				sound_pkg::sb16_voice_r:  if (!pro_mode) vol_voice_r <= wr_byte.sb16.level;
				sound_pkg::sb16_midi_l:   if (!pro_mode) vol_midi_l <= wr_byte.sb16.level;
				sound_pkg::sb16_midi_r:   if (!pro_mode) vol_midi_r <= wr_byte.sb16.level;
				sound_pkg::sb16_cd_l:     if (!pro_mode) vol_cd_l <= wr_byte.sb16.level;
				sound_pkg::sb16_cd_r:     if (!pro_mode) vol_cd_r <= wr_byte.sb16.level;
				sound_pkg::sb16_line_l:   if (!pro_mode) vol_line_l <= wr_byte.sb16.level;
				sound_pkg::sb16_line_r:   if (!pro_mode) vol_line_r <= wr_byte.sb16.level;
				default: ;
			endcase
		end
	end

	// readback value for the current index
	always_comb begin
		case (index)
			sound_pkg::mix_voice:     rd_byte = pro_read(vol_voice_l, vol_voice_r, pro_mode);
			sound_pkg::mix_master:    rd_byte = pro_read(vol_master_l, vol_master_r, pro_mode);
			sound_pkg::mix_midi:      rd_byte = pro_read(vol_midi_l, vol_midi_r, pro_mode);
			sound_pkg::mix_cd:        rd_byte = pro_read(vol_cd_l, vol_cd_r, pro_mode);
			sound_pkg::mix_line:      rd_byte = pro_read(vol_line_l, vol_line_r, pro_mode);
			sound_pkg::sb16_master_l: rd_byte = sb16_read(vol_master_l);
			sound_pkg::sb16_master_r: rd_byte = sb16_read(vol_master_r);
			sound_pkg::sb16_voice_l:  rd_byte = sb16_read(vol_voice_l);
			sound_pkg::sb16_voice_r:  rd_byte = sb16_read(vol_voice_r);
			sound_pkg::sb16_midi_l:   rd_byte = sb16_read(vol_midi_l);
			sound_pkg::sb16_midi_r:   rd_byte = sb16_read(vol_midi_r);
			sound_pkg::sb16_cd_l:     rd_byte = sb16_read(vol_cd_l);
			sound_pkg::sb16_cd_r:     rd_byte = sb16_read(vol_cd_r);
			sound_pkg::sb16_line_l:   rd_byte = sb16_read(vol_line_l);
			sound_pkg::sb16_line_r:   rd_byte = sb16_read(vol_line_r);
			sound_pkg::mix_irq_sel:   rd_byte = {4'h0, irq_sel_10, irq_sel_7, irq_sel_5, 1'b0};
			sound_pkg::mix_irq_stat:  rd_byte = {7'd0, irq8};
			default:                  rd_byte = 8'h00; // unknown index
		endcase
	end

	always_ff @(posedge clk) begin
		mixer_data <= rd_byte;
	end

endmodule

`default_nettype wire

// File: hdl/sound_pkg.sv
// shared constants for the sound card front end
// port offsets, mixer indices, dsp commands and the mixer byte layout
`default_nettype none

package sound_pkg;

	// i/o port offsets within the 16-byte window
	localparam logic [3:0] port_mix_index  = 4'h4;
	localparam logic [3:0] port_mix_data   = 4'h5;
	localparam logic [3:0] port_dsp_reset  = 4'h6;
	localparam logic [3:0] port_dsp_read   = 4'hA;
	localparam logic [3:0] port_dsp_cmd    = 4'hC;
	localparam logic [3:0] port_dsp_status = 4'hE;

	// mixer indices, pro layout
	localparam logic [7:0] mix_reset  = 8'h00;
	localparam logic [7:0] mix_voice  = 8'h04;
	localparam logic [7:0] mix_master = 8'h22;
	localparam logic [7:0] mix_midi   = 8'h26;
	localparam logic [7:0] mix_cd     = 8'h28;
	localparam logic [7:0] mix_line   = 8'h2E;

	// sb16 single channel levels
	localparam logic [7:0] sb16_master_l = 8'h30;
	localparam logic [7:0] sb16_master_r = 8'h31;
	localparam logic [7:0] sb16_voice_l  = 8'h32;
	localparam logic [7:0] sb16_voice_r  = 8'h33;
	localparam logic [7:0] sb16_midi_l   = 8'h34;
	localparam logic [7:0] sb16_midi_r   = 8'h35;
	localparam logic [7:0] sb16_cd_l     = 8'h36;
	localparam logic [7:0] sb16_cd_r     = 8'h37;
	localparam logic [7:0] sb16_line_l   = 8'h38;
	localparam logic [7:0] sb16_line_r   = 8'h39;

	localparam logic [7:0] mix_irq_sel  = 8'h80;
	localparam logic [7:0] mix_irq_stat = 8'h82;

	localparam logic [7:0] mode_pro_on    = 8'hAD; // written to index 80
	localparam logic [7:0] mode_pro_off   = 8'hAE;
	localparam logic [7:0] dsp_ready_byte = 8'hAA;

	localparam logic [4:0]  vol_reset    = 5'h1F;
	localparam logic [15:0] dsp_reset_us = 16'd3; // ticks until ready byte
	localparam logic [27:0] tick_hz      = 28'd1000000;

	// dsp commands
	localparam logic [7:0] cmd_direct_dac = 8'h10;
	localparam logic [7:0] cmd_version    = 8'hE1;
	localparam logic [7:0] cmd_irq8       = 8'hF2;

	localparam logic [7:0] dsp_version_major = 8'h04;
	localparam logic [7:0] dsp_version_minor = 8'h05;

	// one mixer data byte, seen as a pro nibble pair or an sb16 level
	typedef union packed {
		struct packed {
			logic [3:0] left;
			logic [3:0] right;
		} pro;
		struct packed {
			logic [4:0] level;
			logic [2:0] unused;
		} sb16;
	} mixer_byte_u;

endpackage

`default_nettype wire

// File: hdl/sound_rate_tick.sv
// 1 us clock enable from an arbitrary system clock rate
// clock_rate is the clk frequency in Hz, ce_1us pulses one cycle per tick
`timescale 1ns/1ps
`default_nettype none

module sound_rate_tick (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [27:0] clock_rate,
	output logic        ce_1us
);

	logic [27:0] clk_rate; // registered copy of the rate input
	logic [27:0] acc;
	logic [27:0] sum;

	always_ff @(posedge clk) begin
		clk_rate <= clock_rate;
	end

	assign sum = acc + sound_pkg::tick_hz;

	// fractional divider, carries the remainder into the next period
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			acc    <= 28'd0;
			ce_1us <= 1'b0;
		end else if (sum >= clk_rate) begin
			acc    <= sum - clk_rate;
			ce_1us <= 1'b1;
		end else begin
			acc    <= sum;
			ce_1us <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: hdl/sound_volume.sv
// registered attenuation of one signed sample
// the upper four level bits give the shift, level zero mutes
`timescale 1ns/1ps
`default_nettype none

module sound_volume (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [15:0] sample_in,
	input  logic [4:0]  level,
	output logic [15:0] sample_out
);

	logic [3:0]  shift;
	logic [15:0] scaled;

	assign shift = ~level[4:1]; // 1F gives no shift

	always_comb begin
		if (level == 5'd0)
			scaled = 16'd0;
		else
			scaled = $signed(sample_in) >>> shift;
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			sample_out <= 16'd0;
		else
			sample_out <= scaled;
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# builds the sound card testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

obj_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module sound_tb -Mdir "$obj_dir" -f sound.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$obj_dir/Vsound_tb" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx '>>> PASS' "$log_file"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

// File: sound.f
hdl/sound_pkg.sv
hdl/sound_rate_tick.sv
hdl/sound_mixer_regs.sv
hdl/sound_dsp.sv
hdl/sound_volume.sv
hdl/sound.sv
verification/sound_tb.sv

// File: verification/sound_tb.sv
// testbench for the sound card front end
// reads one operation per line from verification/sound_vectors.txt,
// drives the host bus and compares readback, volume, sample and irq outputs
`timescale 1ns/1ps
`default_nettype none

module sound_tb;

	localparam int clk_half       = 20;  // 40 ns period, 25 MHz
	localparam int poll_limit     = 50;  // status reads before giving up
	localparam int cycles_per_vec = 200;

	localparam logic [4:0] vol_full = 5'h1F; // reset level of every volume

	logic        clk;
	logic        rst_n;
	logic [3:0]  address;
	logic        read;
	logic        write;
	logic [7:0]  writedata;
	logic        sb_cs;
	logic [27:0] clock_rate;
	logic        irq_5;
	logic        irq_7;
	logic        irq_10;
	logic [7:0]  readdata;
	logic [4:0]  vol_l;
	logic [4:0]  vol_r;
	logic [4:0]  vol_midi_l;
	logic [4:0]  vol_midi_r;
	logic [4:0]  vol_cd_l;
	logic [4:0]  vol_cd_r;
	logic [4:0]  vol_line_l;
	logic [4:0]  vol_line_r;
	logic [15:0] sample_l;
	logic [15:0] sample_r;

	// vector table, one entry per operation
	logic [7:0]  vec_op[$];
	int          vec_test[$];
	logic [3:0]  vec_addr[$];
	logic [7:0]  vec_data[$];
	logic [15:0] vec_exp_a[$];
	logic [15:0] vec_exp_b[$];
	int          vec_count = 0;
	bit          loaded = 1'b0;

	int cur_test = 0;
	int errors = 0;
	int checks = 0;
	int test_errors = 0;
	int test_checks = 0;
	int tests_passed = 0;
	int tests_failed = 0;

	sound UUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.address    (address),
		.read       (read),
		.write      (write),
		.writedata  (writedata),
		.sb_cs      (sb_cs),
		.clock_rate (clock_rate),
		.irq_5      (irq_5),
		.irq_7      (irq_7),
		.irq_10     (irq_10),
		.readdata   (readdata),
		.vol_l      (vol_l),
		.vol_r      (vol_r),
		.vol_midi_l (vol_midi_l),
		.vol_midi_r (vol_midi_r),
		.vol_cd_l   (vol_cd_l),
		.vol_cd_r   (vol_cd_r),
		.vol_line_l (vol_line_l),
		.vol_line_r (vol_line_r),
		.sample_l   (sample_l),
		.sample_r   (sample_r)
	);

	initial clk = 1'b0;
	always #(clk_half) clk = ~clk;

	task automatic read_vectors();
		int          fd;
		int          n;
		string       line;
		logic [7:0]  op;
		int          tst;
		logic [3:0]  a;
		logic [7:0]  d;
		logic [15:0] ea;
		logic [15:0] eb;
		fd = $fopen("verification/sound_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open verification/sound_vectors.txt");
		end else begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				// skip comment and blank lines
				if (n > 0 && line.len() > 1 && line[0] != "/") begin
					n = $sscanf(line, "%c %d %h %h %h %h", op, tst, a, d, ea, eb);
					if (n == 6) begin
						vec_op.push_back(op);
						vec_test.push_back(tst);
						vec_addr.push_back(a);
						vec_data.push_back(d);
						vec_exp_a.push_back(ea);
						vec_exp_b.push_back(eb);
					end else begin
						$display("malformed vector line: %s", line);
						errors++;
					end
				end
			end
			$fclose(fd);
		end
		vec_count = vec_op.size();
		loaded = 1'b1;
	endtask

	// one host access, strobe for a single cycle, four cycles in all
	task automatic bus_access(input logic [3:0] addr, input logic [7:0] data,
		input logic rd, input logic wr);
		@(posedge clk);
		address   <= addr;
		writedata <= data;
		read      <= rd;
		write     <= wr;
		sb_cs     <= 1'b1;
		@(posedge clk);
		read  <= 1'b0;
		write <= 1'b0;
		sb_cs <= 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk); // outputs settled here
	endtask

	task automatic check_value(input string what, input logic [15:0] got,
		input logic [15:0] exp);
		checks++;
		test_checks++;
		assert (got === exp) else begin
			$display("FAIL %0t: test %0d %s is %h, expected %h", $time, cur_test, what,
				got, exp);
			errors++;
			test_errors++;
		end
	endtask

	// status reads until bit 7 shows a queued byte
	task automatic poll_ready(output bit ready);
		int tries;
		ready = 1'b0;
		tries = 0;
		while (!ready && tries < poll_limit) begin
			bus_access(sound_pkg::port_dsp_status, 8'h00, 1'b1, 1'b0);
			ready = readdata[7];
			tries++;
		end
		if (!ready) begin
			$display("test %0d: the DSP reported no data after %0d status reads", cur_test,
				poll_limit);
			errors++;
			test_errors++;
		end
	endtask

	task automatic finish_test();
		if (test_errors == 0) begin
			$display("test %0d: passed, %0d checks", cur_test, test_checks);
			tests_passed++;
		end else begin
			$display("test %0d: failed, %0d errors in %0d checks", cur_test, test_errors,
				test_checks);
			tests_failed++;
		end
		test_errors = 0;
		test_checks = 0;
	endtask

	task automatic run_vectors();
		bit ready;
		cur_test = vec_test[0];
		for (int i = 0; i < vec_count; i++) begin
			if (vec_test[i] != cur_test) begin
				finish_test();
				cur_test = vec_test[i];
			end
			case (vec_op[i])
				"W": bus_access(vec_addr[i], vec_data[i], 1'b0, 1'b1);
				"R": begin
					bus_access(vec_addr[i], 8'h00, 1'b1, 1'b0);
					check_value("readdata", {8'h00, readdata}, vec_exp_a[i]);
				end
				"P": begin
					poll_ready(ready);
					if (ready) begin
						bus_access(sound_pkg::port_dsp_read, 8'h00, 1'b1, 1'b0);
						check_value("queued byte", {8'h00, readdata}, vec_exp_a[i]);
					end
				end
				"S": begin
					check_value("sample_l", sample_l, vec_exp_a[i]);
					check_value("sample_r", sample_r, vec_exp_b[i]);
				end
				"V": begin
					check_value("vol_l", {11'd0, vol_l}, vec_exp_a[i]);
					check_value("vol_r", {11'd0, vol_r}, vec_exp_b[i]);
					// no vector writes midi, cd or line, so they keep the reset level
					check_value("vol_midi_l", {11'd0, vol_midi_l}, {11'd0, vol_full});
					check_value("vol_midi_r", {11'd0, vol_midi_r}, {11'd0, vol_full});
					check_value("vol_cd_l", {11'd0, vol_cd_l}, {11'd0, vol_full});
					check_value("vol_cd_r", {11'd0, vol_cd_r}, {11'd0, vol_full});
					check_value("vol_line_l", {11'd0, vol_line_l}, {11'd0, vol_full});
					check_value("vol_line_r", {11'd0, vol_line_r}, {11'd0, vol_full});
				end
				"I": check_value("irq 5/7/10", {13'd0, irq_5, irq_7, irq_10}, vec_exp_a[i]);
				default: begin
					$display("test %0d: unknown operation code %h in the vector file",
						cur_test, vec_op[i]);
					errors++;
					test_errors++;
				end
			endcase
		end
		finish_test();
	endtask

	initial begin
		rst_n      <= 1'b0;
		address    <= 4'h0;
		read       <= 1'b0;
		write      <= 1'b0;
		writedata  <= 8'h00;
		sb_cs      <= 1'b0;
		clock_rate <= 28'd25000000;
		read_vectors();
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		if (vec_count == 0) begin
			$display("no operations were read from the vector file");
			errors++;
		end else begin
			run_vectors();
		end
		$display("%0d tests passed, %0d failed, %0d checks, %0d errors", tests_passed,
			tests_failed, checks, errors);
		if (errors == 0 && tests_failed == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	// watchdog, budget scales with the vector count
	initial begin
		wait (loaded);
		repeat ((vec_count + 1) * cycles_per_vec) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run did not finish",
			(vec_count + 1) * cycles_per_vec);
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/sound_vectors.txt
// op test addr data exp_a exp_b, all hex except op and test
// W write, R read, P poll then read port A, S samples l r, V vol_l vol_r, I irq {5,7,10}
// dsp reset and ready byte
W 1 6 01 0000 0000
W 1 6 00 0000 0000
P 1 0 00 00aa 0000
R 1 e 00 0000 0000
// version query, irq routing
W 2 c e1 0000 0000
P 2 0 00 0004 0000
P 2 0 00 0005 0000
R 2 e 00 0000 0000
W 2 c f2 0000 0000
I 2 0 00 0004 0000
R 2 e 00 0000 0000
I 2 0 00 0000 0000
W 2 4 80 0000 0000
W 2 5 04 0000 0000
W 2 c f2 0000 0000
I 2 0 00 0002 0000
R 2 5 00 0004 0000
W 2 4 82 0000 0000
R 2 5 00 0001 0000
R 2 e 00 0000 0000
I 2 0 00 0000 0000
// mixer reset values
W 3 4 22 0000 0000
R 3 5 00 00ff 0000
W 3 4 30 0000 0000
R 3 5 00 00f8 0000
V 3 0 00 001f 001f
S 3 0 00 0000 0000
// sb16 layout, nibble 5 expands to 0a
W 4 4 30 0000 0000
W 4 5 90 0000 0000
V 4 0 00 0012 001f
R 4 5 00 0090 0000
W 4 4 22 0000 0000
W 4 5 5a 0000 0000
V 4 0 00 000a 0015
R 4 5 00 005a 0000
// pro mode lockout and masked readback
W 5 4 80 0000 0000
W 5 5 ad 0000 0000
W 5 4 31 0000 0000
W 5 5 40 0000 0000
V 5 0 00 000a 0015
W 5 4 22 0000 0000
R 5 5 00 004a 0000
W 5 4 80 0000 0000
W 5 5 ae 0000 0000
W 5 4 31 0000 0000
W 5 5 40 0000 0000
V 5 0 00 000a 0008
W 5 4 22 0000 0000
R 5 5 00 0054 0000
W 5 4 00 0000 0000
W 5 5 00 0000 0000
V 5 0 00 001f 001f
W 5 4 22 0000 0000
R 5 5 00 00ff 0000
// direct dac and voice volume
W 6 c 10 0000 0000
W 6 c c0 0000 0000
S 6 0 00 4000 4000
W 6 4 32 0000 0000
W 6 5 00 0000 0000
S 6 0 00 0000 4000
W 6 4 33 0000 0000
W 6 5 b8 0000 0000
S 6 0 00 0000 0400
